//--- hw/ccu_macros.svh
`ifndef CCU_MACROS_SVH
`define CCU_MACROS_SVH

// Address and data widths of all ACE channels
`define CCU_ADDR_W 32
`define CCU_DATA_W 32

// One strobe bit per data byte
`define CCU_STRB_W (`CCU_DATA_W / 8)

// Beats per cache line and thus the length of a write-back burst
`define CCU_LINE_BEATS 4

`endif

//--- hw/ccu_pkg.sv
`default_nettype none

`include "ccu_macros.svh"

package ccu_pkg;

    // AXI burst types
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // Shareability domain carried on AW and AC
    typedef enum logic [1:0] {
        NON_SHAREABLE = 2'b00,
        INNER         = 2'b01,
        OUTER         = 2'b10,
        SYSTEM        = 2'b11
    } axdomain_e;

    // Shareable write opcodes from the cached master
    typedef enum logic [2:0] {
        WRITE_UNIQUE      = 3'b000,
        WRITE_LINE_UNIQUE = 3'b001
    } awsnoop_e;

    // Snoop opcodes issued on AC
    typedef enum logic [3:0] {
        CLEAN_INVALID = 4'b1001,
        MAKE_INVALID  = 4'b1101
    } acsnoop_e;

    typedef enum logic [1:0] {
        SNOOP_REQ,
        SNOOP_RESP,
        WRITE_CD,
        WRITE_W
    } wr_state_e;

    typedef struct packed {
        logic [`CCU_ADDR_W-1:0] addr;
        logic [7:0]             len;
        burst_e                 burst;
        logic [2:0]             prot;
        awsnoop_e               snoop;
        axdomain_e              domain;
    } aw_chan_t;

    typedef struct packed {
        logic [`CCU_DATA_W-1:0] data;
        logic [`CCU_STRB_W-1:0] strb;
        logic                   last;
    } w_chan_t;

    typedef logic [1:0] b_chan_t;

    typedef struct packed {
        logic [`CCU_ADDR_W-1:0] addr;
        acsnoop_e               snoop;
        logic [2:0]             prot;
        axdomain_e              domain;
    } ac_chan_t;

    // Snoop response flags in the bit order of ACE CRRESP[4:0]
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic error;
        logic data_transfer;
    } cr_resp_t;

    typedef struct packed {
        logic [`CCU_DATA_W-1:0] data;
        logic                   last;
    } cd_chan_t;

endpackage

`default_nettype wire

//--- hw/ccu_wr_aw_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_wr_aw_decoder (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire ccu_pkg::aw_chan_t slv_aw_i,
    input  wire logic              slv_aw_valid_i,
    output logic                   slv_aw_ready_o,
    output ccu_pkg::aw_chan_t      dec_aw_o,
    output ccu_pkg::acsnoop_e      dec_snoop_o,
    output logic                   dec_valid_o,
    input  wire logic              dec_ready_i
);

    import ccu_pkg::*;

    logic      full_q;
    logic      aw_take;
    aw_chan_t  aw_q;
    acsnoop_e  snoop_q;

    // Unique write needs the line cleaned, full-line write only invalidated
    function automatic acsnoop_e map_snoop(awsnoop_e op);
        case (op)
            WRITE_LINE_UNIQUE: return MAKE_INVALID;
            default:           return CLEAN_INVALID;
        endcase
    endfunction

    assign slv_aw_ready_o = !full_q;
    assign aw_take        = slv_aw_valid_i && slv_aw_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (aw_take) begin
            full_q <= 1'b1;
        end else if (dec_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // Decode once on load so the FSM sees a ready-made opcode
    always_ff @(posedge clk_i) begin
        if (aw_take) begin
            aw_q    <= slv_aw_i;
            snoop_q <= map_snoop(slv_aw_i.snoop);
        end
    end

    assign dec_aw_o    = aw_q;
    assign dec_snoop_o = snoop_q;
    assign dec_valid_o = full_q;

    // Only shareable writes with a known opcode are routed to this port
    a_shareable_known_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_take |-> (slv_aw_i.domain != NON_SHAREABLE) &&
                    (slv_aw_i.snoop inside {WRITE_UNIQUE, WRITE_LINE_UNIQUE}))
        else $error("AW accepted with non-shareable domain or unknown opcode");

endmodule

`default_nettype wire

//--- hw/ccu_wr_snoop_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_macros.svh"

module ccu_wr_snoop_fsm (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire ccu_pkg::aw_chan_t dec_aw_i,
    input  wire ccu_pkg::acsnoop_e dec_snoop_i,
    input  wire logic              dec_valid_i,
    output logic                   dec_ready_o,
    input  wire ccu_pkg::w_chan_t  slv_w_i,
    input  wire logic              slv_w_valid_i,
    output logic                   slv_w_ready_o,
    output ccu_pkg::b_chan_t       slv_b_o,
    output logic                   slv_b_valid_o,
    input  wire logic              slv_b_ready_i,
    output ccu_pkg::ac_chan_t      ac_o,
    output logic                   ac_valid_o,
    input  wire logic              ac_ready_i,
    input  wire ccu_pkg::cr_resp_t cr_i,
    input  wire logic              cr_valid_i,
    output logic                   cr_ready_o,
    input  wire ccu_pkg::cd_chan_t cd_i,
    input  wire logic              cd_valid_i,
    output logic                   cd_ready_o,
    output ccu_pkg::aw_chan_t      mem_aw_o,
    output logic                   mem_aw_valid_o,
    input  wire logic              mem_aw_ready_i,
    output ccu_pkg::w_chan_t       mem_w_o,
    output logic                   mem_w_valid_o,
    input  wire logic              mem_w_ready_i,
    input  wire ccu_pkg::b_chan_t  mem_b_i,
    input  wire logic              mem_b_valid_i,
    output logic                   mem_b_ready_o
);

    import ccu_pkg::*;

    wr_state_e state_d, state_q;
    aw_chan_t  aw_q;
    logic      aw_valid_d, aw_valid_q;
    logic      w_last_d, w_last_q;
    logic      cd_last_d, cd_last_q;
    logic      ignore_cd_d, ignore_cd_q;
    logic      ac_take, cd_take, w_take, b_take;

    assign ac_take = ac_valid_o && ac_ready_i;
    assign cd_take = cd_valid_i && cd_ready_o;
    assign w_take  = slv_w_valid_i && slv_w_ready_o;
    assign b_take  = mem_b_valid_i && mem_b_ready_o;

    // Snoop request is a straight copy of the decoded AW
    assign ac_o.addr   = dec_aw_i.addr;
    assign ac_o.snoop  = dec_snoop_i;
    assign ac_o.prot   = dec_aw_i.prot;
    assign ac_o.domain = dec_aw_i.domain;

    assign mem_aw_valid_o = aw_valid_q;
    assign slv_b_o        = mem_b_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= SNOOP_REQ;
            aw_valid_q  <= 1'b0;
            w_last_q    <= 1'b0;
            cd_last_q   <= 1'b0;
            ignore_cd_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            aw_valid_q  <= aw_valid_d;
            w_last_q    <= w_last_d;
            cd_last_q   <= cd_last_d;
            ignore_cd_q <= ignore_cd_d;
        end
    end

    // Hold the AW for the whole transaction once the snoop is out
    always_ff @(posedge clk_i) begin
        if (ac_take) begin
            aw_q <= dec_aw_i;
        end
    end

    always_comb begin
        state_d       = state_q;
        aw_valid_d    = aw_valid_q;
        w_last_d      = w_last_q;
        cd_last_d     = cd_last_q;
        ignore_cd_d   = ignore_cd_q;
        dec_ready_o   = 1'b0;
        ac_valid_o    = 1'b0;
        cr_ready_o    = 1'b0;
        cd_ready_o    = 1'b0;
        slv_w_ready_o = 1'b0;
        slv_b_valid_o = 1'b0;
        mem_b_ready_o = 1'b0;
        mem_aw_o      = aw_q;
        mem_w_o       = slv_w_i;
        mem_w_valid_o = 1'b0;

        case (state_q)
            SNOOP_REQ: begin
                w_last_d    = 1'b0;
                cd_last_d   = 1'b0;
                ignore_cd_d = 1'b0;
                ac_valid_o  = dec_valid_i;
                dec_ready_o = ac_ready_i;
                if (ac_take) begin
                    state_d = SNOOP_RESP;
                end
            end
            SNOOP_RESP: begin
                cr_ready_o = 1'b1;
                if (cr_valid_i) begin
                    if (cr_i.data_transfer) begin
                        // Clean or faulty data is drained but never written
                        if (cr_i.error || !cr_i.pass_dirty) begin
                            ignore_cd_d = 1'b1;
                        end else begin
                            aw_valid_d = 1'b1;
                        end
                        state_d = WRITE_CD;
                    end else begin
                        aw_valid_d = 1'b1;
                        state_d    = WRITE_W;
                    end
                end
            end
            WRITE_CD: begin
                // Snoop data arrives as a wrapped full line
                mem_aw_o.len   = 8'(`CCU_LINE_BEATS - 1);
                mem_aw_o.burst = WRAP;
                mem_w_o.data   = cd_i.data;
                mem_w_o.strb   = '1;
                mem_w_o.last   = cd_i.last;
                mem_w_valid_o  = cd_valid_i && !cd_last_q && !ignore_cd_q;
                cd_ready_o     = !cd_last_q && (ignore_cd_q || mem_w_ready_i);
                // Write-back response stays inside the port
                mem_b_ready_o  = 1'b1;
                if (cd_take && cd_i.last) begin
                    cd_last_d = 1'b1;
                end
                if (mem_aw_ready_i) begin
                    aw_valid_d = 1'b0;
                end
                if (b_take || (cd_last_q && ignore_cd_q)) begin
                    aw_valid_d = 1'b1;
                    state_d    = WRITE_W;
                end
            end
            WRITE_W: begin
                mem_w_valid_o = slv_w_valid_i && !w_last_q;
                slv_w_ready_o = mem_w_ready_i && !w_last_q;
                slv_b_valid_o = mem_b_valid_i;
                mem_b_ready_o = slv_b_ready_i;
                if (w_take && slv_w_i.last) begin
                    w_last_d = 1'b1;
                end
                if (mem_aw_ready_i) begin
                    aw_valid_d = 1'b0;
                end
                if (b_take) begin
                    state_d = SNOOP_REQ;
                end
            end
            default: begin
                state_d = SNOOP_REQ;
            end
        endcase
    end

    // Master data may only follow its own AW into the memory port
    a_w_only_in_write_w: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_take |-> state_q == WRITE_W && !aw_valid_q)
        else $error("master W accepted outside WRITE_W or ahead of its AW");

    // A stalled memory beat must not be withdrawn
    a_mem_w_valid_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o)
        else $error("memory W valid dropped under back-pressure");

endmodule

`default_nettype wire

//--- hw/ccu_mem_wr_port.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_mem_wr_port (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire ccu_pkg::aw_chan_t aw_i,
    input  wire logic              aw_valid_i,
    output logic                   aw_ready_o,
    input  wire ccu_pkg::w_chan_t  w_i,
    input  wire logic              w_valid_i,
    output logic                   w_ready_o,
    output ccu_pkg::b_chan_t       b_o,
    output logic                   b_valid_o,
    input  wire logic              b_ready_i,
    output ccu_pkg::aw_chan_t      mem_aw_o,
    output logic                   mem_aw_valid_o,
    input  wire logic              mem_aw_ready_i,
    output ccu_pkg::w_chan_t       mem_w_o,
    output logic                   mem_w_valid_o,
    input  wire logic              mem_w_ready_i,
    input  wire ccu_pkg::b_chan_t  mem_b_i,
    input  wire logic              mem_b_valid_i,
    output logic                   mem_b_ready_o
);

    import ccu_pkg::*;

    aw_chan_t   aw_q;
    w_chan_t    w_q;
    logic       aw_full_q, w_full_q;
    logic       burst_open_q;
    logic [7:0] beat_cnt_q;
    logic       aw_take, w_take, w_final;

    // A new burst waits until the previous one has sent all its beats
    assign aw_ready_o = !burst_open_q && (!aw_full_q || mem_aw_ready_i);
    assign w_ready_o  = burst_open_q && (!w_full_q || mem_w_ready_i);
    assign aw_take    = aw_valid_i && aw_ready_o;
    assign w_take     = w_valid_i && w_ready_o;
    assign w_final    = beat_cnt_q == aw_q.len;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_full_q    <= 1'b0;
            w_full_q     <= 1'b0;
            burst_open_q <= 1'b0;
            beat_cnt_q   <= '0;
        end else begin
            if (aw_take) begin
                aw_full_q <= 1'b1;
            end else if (mem_aw_ready_i) begin
                aw_full_q <= 1'b0;
            end
            if (w_take) begin
                w_full_q <= 1'b1;
            end else if (mem_w_ready_i) begin
                w_full_q <= 1'b0;
            end
            if (aw_take) begin
                burst_open_q <= 1'b1;
                beat_cnt_q   <= '0;
            end else if (w_take) begin
                burst_open_q <= !w_final;
                beat_cnt_q   <= beat_cnt_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_take) begin
            aw_q <= aw_i;
        end
        if (w_take) begin
            w_q <= w_i;
        end
    end

    assign mem_aw_o       = aw_q;
    assign mem_aw_valid_o = aw_full_q;
    assign mem_w_o        = w_q;
    assign mem_w_valid_o  = w_full_q;

    // Responses need no buffering
    assign b_o           = mem_b_i;
    assign b_valid_o     = mem_b_valid_i;
    assign mem_b_ready_o = b_ready_i;

    a_last_on_final_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_take |-> w_i.last == w_final)
        else $error("W last does not match burst length");

endmodule

`default_nettype wire

//--- hw/ccu_wr_top.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_wr_top (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire ccu_pkg::aw_chan_t slv_aw_i,
    input  wire logic              slv_aw_valid_i,
    output logic                   slv_aw_ready_o,
    input  wire ccu_pkg::w_chan_t  slv_w_i,
    input  wire logic              slv_w_valid_i,
    output logic                   slv_w_ready_o,
    output ccu_pkg::b_chan_t       slv_b_o,
    output logic                   slv_b_valid_o,
    input  wire logic              slv_b_ready_i,
    output ccu_pkg::ac_chan_t      ac_o,
    output logic                   ac_valid_o,
    input  wire logic              ac_ready_i,
    input  wire ccu_pkg::cr_resp_t cr_i,
    input  wire logic              cr_valid_i,
    output logic                   cr_ready_o,
    input  wire ccu_pkg::cd_chan_t cd_i,
    input  wire logic              cd_valid_i,
    output logic                   cd_ready_o,
    output ccu_pkg::aw_chan_t      mem_aw_o,
    output logic                   mem_aw_valid_o,
    input  wire logic              mem_aw_ready_i,
    output ccu_pkg::w_chan_t       mem_w_o,
    output logic                   mem_w_valid_o,
    input  wire logic              mem_w_ready_i,
    input  wire ccu_pkg::b_chan_t  mem_b_i,
    input  wire logic              mem_b_valid_i,
    output logic                   mem_b_ready_o
);

    import ccu_pkg::*;

    // Decoder to FSM
    aw_chan_t dec_aw;
    acsnoop_e dec_snoop;
    logic     dec_valid, dec_ready;

    // FSM to memory port
    aw_chan_t fsm_aw;
    logic     fsm_aw_valid, fsm_aw_ready;
    w_chan_t  fsm_w;
    logic     fsm_w_valid, fsm_w_ready;
    b_chan_t  fsm_b;
    logic     fsm_b_valid, fsm_b_ready;

    ccu_wr_aw_decoder u_aw_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_aw_i       (slv_aw_i),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .dec_aw_o       (dec_aw),
        .dec_snoop_o    (dec_snoop),
        .dec_valid_o    (dec_valid),
        .dec_ready_i    (dec_ready)
    );

    ccu_wr_snoop_fsm u_snoop_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dec_aw_i       (dec_aw),
        .dec_snoop_i    (dec_snoop),
        .dec_valid_i    (dec_valid),
        .dec_ready_o    (dec_ready),
        .slv_w_i        (slv_w_i),
        .slv_w_valid_i  (slv_w_valid_i),
        .slv_w_ready_o  (slv_w_ready_o),
        .slv_b_o        (slv_b_o),
        .slv_b_valid_o  (slv_b_valid_o),
        .slv_b_ready_i  (slv_b_ready_i),
        .ac_o           (ac_o),
        .ac_valid_o     (ac_valid_o),
        .ac_ready_i     (ac_ready_i),
        .cr_i           (cr_i),
        .cr_valid_i     (cr_valid_i),
        .cr_ready_o     (cr_ready_o),
        .cd_i           (cd_i),
        .cd_valid_i     (cd_valid_i),
        .cd_ready_o     (cd_ready_o),
        .mem_aw_o       (fsm_aw),
        .mem_aw_valid_o (fsm_aw_valid),
        .mem_aw_ready_i (fsm_aw_ready),
        .mem_w_o        (fsm_w),
        .mem_w_valid_o  (fsm_w_valid),
        .mem_w_ready_i  (fsm_w_ready),
        .mem_b_i        (fsm_b),
        .mem_b_valid_i  (fsm_b_valid),
        .mem_b_ready_o  (fsm_b_ready)
    );

    ccu_mem_wr_port u_mem_wr_port (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .aw_i           (fsm_aw),
        .aw_valid_i     (fsm_aw_valid),
        .aw_ready_o     (fsm_aw_ready),
        .w_i            (fsm_w),
        .w_valid_i      (fsm_w_valid),
        .w_ready_o      (fsm_w_ready),
        .b_o            (fsm_b),
        .b_valid_o      (fsm_b_valid),
        .b_ready_i      (fsm_b_ready),
        .mem_aw_o       (mem_aw_o),
        .mem_aw_valid_o (mem_aw_valid_o),
        .mem_aw_ready_i (mem_aw_ready_i),
        .mem_w_o        (mem_w_o),
        .mem_w_valid_o  (mem_w_valid_o),
        .mem_w_ready_i  (mem_w_ready_i),
        .mem_b_i        (mem_b_i),
        .mem_b_valid_i  (mem_b_valid_i),
        .mem_b_ready_o  (mem_b_ready_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

    // 10 ns period
    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb/ccu_wr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_macros.svh"

module ccu_wr_tb;

    import ccu_pkg::*;

    localparam int NUM_WR  = 200;
    localparam int TIMEOUT = 5000;

    logic clk, rst_n;

    aw_chan_t slv_aw_i;
    logic     slv_aw_valid_i, slv_aw_ready_o;
    w_chan_t  slv_w_i;
    logic     slv_w_valid_i, slv_w_ready_o;
    b_chan_t  slv_b_o;
    logic     slv_b_valid_o, slv_b_ready_i;
    ac_chan_t ac_o;
    logic     ac_valid_o, ac_ready_i;
    cr_resp_t cr_i;
    logic     cr_valid_i, cr_ready_o;
    cd_chan_t cd_i;
    logic     cd_valid_i, cd_ready_o;
    aw_chan_t mem_aw_o;
    logic     mem_aw_valid_o, mem_aw_ready_i;
    w_chan_t  mem_w_o;
    logic     mem_w_valid_o, mem_w_ready_i;
    b_chan_t  mem_b_i;
    logic     mem_b_valid_i, mem_b_ready_o;

    integer seed = 8559;
    bit     started = 1'b0;
    bit     done = 1'b0;

    // Stimulus for every write is generated up front
    aw_chan_t    wr_aw   [NUM_WR];
    logic [31:0] wr_data [NUM_WR][8];
    logic [3:0]  wr_strb [NUM_WR][8];
    logic [31:0] cd_data [NUM_WR][`CCU_LINE_BEATS];

    // Expected memory bursts in order
    // Kind 0 is a write-back and kind 1 the master write
    int       exp_kind_q[$];
    int       exp_idx_q[$];
    aw_chan_t mem_aw_q[$];
    w_chan_t  mem_beat_q[$];
    int       bursts_done = 0;
    b_chan_t  slv_b_exp_q[$];
    int       b_count = 0;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    ccu_wr_top DUT (
        .clk_i (clk), .rst_ni (rst_n),
        .slv_aw_i (slv_aw_i), .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .slv_w_i (slv_w_i), .slv_w_valid_i (slv_w_valid_i), .slv_w_ready_o (slv_w_ready_o),
        .slv_b_o (slv_b_o), .slv_b_valid_o (slv_b_valid_o), .slv_b_ready_i (slv_b_ready_i),
        .ac_o (ac_o), .ac_valid_o (ac_valid_o), .ac_ready_i (ac_ready_i),
        .cr_i (cr_i), .cr_valid_i (cr_valid_i), .cr_ready_o (cr_ready_o),
        .cd_i (cd_i), .cd_valid_i (cd_valid_i), .cd_ready_o (cd_ready_o),
        .mem_aw_o (mem_aw_o), .mem_aw_valid_o (mem_aw_valid_o),
        .mem_aw_ready_i (mem_aw_ready_i),
        .mem_w_o (mem_w_o), .mem_w_valid_o (mem_w_valid_o), .mem_w_ready_i (mem_w_ready_i),
        .mem_b_i (mem_b_i), .mem_b_valid_i (mem_b_valid_i), .mem_b_ready_o (mem_b_ready_o)
    );

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    task automatic report_mismatch(string test, logic [63:0] exp, logic [63:0] act);
        $display("Mismatch %s: expected %0h, actual %0h", test, exp, act);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(string what);
        $display("Error: %s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Waits one to four rising edges and then the 1 ns drive delay
    task automatic idle_cycles();
        logic [31:0] r;
        r = next_random();
        repeat (int'(r[1:0]) + 1) @(posedge clk);
        #1;
    endtask

    task automatic make_writes();
        logic [31:0] r;
        for (int i = 0; i < NUM_WR; i++) begin
            r = next_random();
            wr_aw[i].addr   = next_random();
            wr_aw[i].len    = {5'd0, r[2:0]};
            wr_aw[i].burst  = INCR;
            wr_aw[i].prot   = r[5:3];
            wr_aw[i].snoop  = r[6] ? WRITE_LINE_UNIQUE : WRITE_UNIQUE;
            wr_aw[i].domain = (r[8:7] == 2'd0) ? SYSTEM : axdomain_e'(r[8:7]);
            for (int j = 0; j < 8; j++) begin
                r = next_random();
                wr_data[i][j] = next_random();
                wr_strb[i][j] = r[3:0];
            end
            for (int j = 0; j < `CCU_LINE_BEATS; j++) begin
                cd_data[i][j] = next_random();
            end
        end
    endtask

    // Master side sends AW and W beats in order without waiting for B
    task automatic drive_master();
        int cnt;
        for (int i = 0; i < NUM_WR; i++) begin
            idle_cycles();
            slv_aw_i       = wr_aw[i];
            slv_aw_valid_i = 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_plain("master AW was never accepted");
            end while (!slv_aw_ready_o);
            #1 slv_aw_valid_i = 1'b0;
            for (int j = 0; j <= int'(wr_aw[i].len); j++) begin
                slv_w_i.data  = wr_data[i][j];
                slv_w_i.strb  = wr_strb[i][j];
                slv_w_i.last  = (j == int'(wr_aw[i].len));
                slv_w_valid_i = 1'b1;
                cnt = 0;
                do begin
                    @(posedge clk);
                    cnt++;
                    if (cnt > TIMEOUT) fail_plain("master W beat was never accepted");
                end while (!slv_w_ready_o);
                #1 slv_w_valid_i = 1'b0;
            end
        end
    endtask

    // Snooped cache answers each AC with random CR flags and optional CD data
    task automatic model_cache();
        int       cnt;
        acsnoop_e exp_op;
        logic     dirty;
        logic [31:0] r;
        for (int n = 0; n < NUM_WR; n++) begin
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_plain("no snoop request on AC");
            end while (!(ac_valid_o && ac_ready_i));
            exp_op = (wr_aw[n].snoop == WRITE_LINE_UNIQUE) ? MAKE_INVALID : CLEAN_INVALID;
            assert (ac_o.snoop == exp_op)
                else report_mismatch("ac_snoop", 64'(exp_op), 64'(ac_o.snoop));
            assert (ac_o.addr == wr_aw[n].addr)
                else report_mismatch("ac_addr", 64'(wr_aw[n].addr), 64'(ac_o.addr));
            assert (ac_o.prot == wr_aw[n].prot)
                else report_mismatch("ac_prot", 64'(wr_aw[n].prot), 64'(ac_o.prot));
            assert (ac_o.domain == wr_aw[n].domain)
                else report_mismatch("ac_domain", 64'(wr_aw[n].domain), 64'(ac_o.domain));
            idle_cycles();
            r = next_random();
            cr_i       = cr_resp_t'(r[4:0]);
            cr_valid_i = 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_plain("CR was never accepted");
            end while (!cr_ready_o);
            dirty = cr_i.data_transfer && !cr_i.error && cr_i.pass_dirty;
            if (dirty) begin
                exp_kind_q.push_back(0);
                exp_idx_q.push_back(n);
            end
            exp_kind_q.push_back(1);
            exp_idx_q.push_back(n);
            #1 cr_valid_i = 1'b0;
            if (cr_i.data_transfer) begin
                for (int j = 0; j < `CCU_LINE_BEATS; j++) begin
                    idle_cycles();
                    cd_i.data  = cd_data[n][j];
                    cd_i.last  = (j == `CCU_LINE_BEATS - 1);
                    cd_valid_i = 1'b1;
                    cnt = 0;
                    do begin
                        @(posedge clk);
                        cnt++;
                        if (cnt > TIMEOUT) fail_plain("CD beat was never accepted");
                    end while (!cd_ready_o);
                    #1 cd_valid_i = 1'b0;
                end
            end
        end
    endtask

    // Pops one finished memory burst and checks it against the expected one
    task automatic check_burst(output logic is_master);
        aw_chan_t aw;
        w_chan_t  beat;
        int       kind, idx;
        aw = mem_aw_q.pop_front();
        if (exp_kind_q.size() == 0) fail_plain("memory burst arrived with none expected");
        if (mem_beat_q.size() < int'(aw.len) + 1) fail_plain("memory burst is short of beats");
        kind = exp_kind_q.pop_front();
        idx  = exp_idx_q.pop_front();
        is_master = (kind == 1);
        if (kind == 0) begin
            assert (aw.addr == wr_aw[idx].addr)
                else report_mismatch("wb_addr", 64'(wr_aw[idx].addr), 64'(aw.addr));
            assert (aw.len == 8'(`CCU_LINE_BEATS - 1))
                else report_mismatch("wb_len", 64'(`CCU_LINE_BEATS - 1), 64'(aw.len));
            assert (aw.burst == WRAP)
                else report_mismatch("wb_burst", 64'(WRAP), 64'(aw.burst));
        end else begin
            assert (aw == wr_aw[idx])
                else report_mismatch("master_aw", 64'(wr_aw[idx]), 64'(aw));
        end
        for (int j = 0; j <= int'(aw.len); j++) begin
            beat = mem_beat_q.pop_front();
            if (kind == 0) begin
                assert (beat.data == cd_data[idx][j])
                    else report_mismatch("wb_data", 64'(cd_data[idx][j]), 64'(beat.data));
                assert (beat.strb == 4'hf)
                    else report_mismatch("wb_strb", 64'hf, 64'(beat.strb));
            end else begin
                assert (beat.data == wr_data[idx][j])
                    else report_mismatch("w_data", 64'(wr_data[idx][j]), 64'(beat.data));
                assert (beat.strb == wr_strb[idx][j])
                    else report_mismatch("w_strb", 64'(wr_strb[idx][j]), 64'(beat.strb));
            end
            assert (beat.last == (j == int'(aw.len)))
                else report_mismatch("w_last", 64'(j == int'(aw.len)), 64'(beat.last));
        end
    endtask

    // Memory answers each finished burst with a random response code
    task automatic model_memory();
        int          cnt;
        logic        is_master;
        logic [31:0] r;
        while (!done) begin
            cnt = 0;
            while (!done && !(mem_aw_q.size() > 0 && bursts_done > 0)) begin
                @(posedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_plain("memory burst never completed");
            end
            if (done) break;
            bursts_done--;
            check_burst(is_master);
            idle_cycles();
            r = next_random();
            mem_b_i       = r[1:0];
            mem_b_valid_i = 1'b1;
            if (is_master) slv_b_exp_q.push_back(r[1:0]);
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_plain("memory B was never accepted");
                if (!is_master) begin
                    assert (!slv_b_valid_o)
                        else fail_plain("write-back response reached the master");
                end
            end while (!mem_b_ready_o);
            #1 mem_b_valid_i = 1'b0;
        end
    endtask

    // Random back-pressure on every ready the testbench owns
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        if (started) begin
            r = next_random();
            ac_ready_i     = r[1:0] != 2'd0;
            mem_aw_ready_i = r[3:2] != 2'd0;
            mem_w_ready_i  = r[5:4] != 2'd0;
            slv_b_ready_i  = r[7:6] != 2'd0;
        end
    end

    always @(posedge clk) begin
        if (started && mem_aw_valid_o && mem_aw_ready_i) begin
            mem_aw_q.push_back(mem_aw_o);
        end
        if (started && mem_w_valid_o && mem_w_ready_i) begin
            mem_beat_q.push_back(mem_w_o);
            if (mem_w_o.last) bursts_done++;
        end
        if (started && slv_b_valid_o && slv_b_ready_i) begin
            if (slv_b_exp_q.size() == 0) fail_plain("master B with no memory B behind it");
            assert (slv_b_o == slv_b_exp_q[0])
                else report_mismatch("slv_b", 64'(slv_b_exp_q[0]), 64'(slv_b_o));
            void'(slv_b_exp_q.pop_front());
            b_count++;
        end
    end

    initial begin
        int cnt;
        slv_aw_i = '0;
        slv_aw_valid_i = 1'b0;
        slv_w_i = '0;
        slv_w_valid_i = 1'b0;
        slv_b_ready_i = 1'b0;
        ac_ready_i = 1'b0;
        cr_i = '0;
        cr_valid_i = 1'b0;
        cd_i = '0;
        cd_valid_i = 1'b0;
        mem_aw_ready_i = 1'b0;
        mem_w_ready_i = 1'b0;
        mem_b_i = '0;
        mem_b_valid_i = 1'b0;
        make_writes();

        // Outputs must stay quiet through reset and a few idle cycles after it
        repeat (12) begin
            @(posedge clk);
            assert (!slv_b_valid_o && !ac_valid_o && !mem_aw_valid_o && !mem_w_valid_o)
                else fail_plain("a valid output is high before stimulus");
            if (rst_n) begin
                assert (!cr_ready_o && !cd_ready_o && !slv_w_ready_o &&
                        !mem_b_ready_o && slv_aw_ready_o)
                    else fail_plain("ready outputs wrong after reset");
            end
        end
        started = 1'b1;

        fork
            drive_master();
            model_cache();
            model_memory();
        join_none

        cnt = 0;
        while (b_count < NUM_WR) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT * 40) fail_plain("not all writes completed");
        end
        done = 1'b1;
        repeat (20) @(posedge clk);

        if (b_count == NUM_WR && exp_kind_q.size() == 0 && mem_aw_q.size() == 0 &&
            mem_beat_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_plain("extra master B or leftover memory traffic");
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/ccu_pkg.sv
hw/ccu_wr_aw_decoder.sv
hw/ccu_wr_snoop_fsm.sv
hw/ccu_mem_wr_port.sv
hw/ccu_wr_top.sv
tb/tb_clk_gen.sv
tb/ccu_wr_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module ccu_wr_tb -o ccu_wr_sim

out=$(./obj_dir/ccu_wr_sim || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "^TEST PASS$"
